// File: include/ioPeriph_consts.svh
`ifndef IOPERIPH_CONSTS_SVH
`define IOPERIPH_CONSTS_SVH

// Register offsets, matched against the low 16 address bits.
`define REG_TIMER_LO	16'hE000
`define REG_TIMER_HI	16'hE004
`define REG_RX_DATA		16'hE010
`define REG_TX_DATA		16'hE014
`define REG_STATUS		16'hE018
`define REG_PINS		16'hE100
`define REG_OUT			16'hE104
`define REG_DIR			16'hE108
`define REG_SET			16'hE110
`define REG_CLEAR		16'hE114

`define TICK_DIV		4	// Clocks per microsecond tick.
`define BIT_CLKS		8	// Clocks per UART bit.
`define FIFO_DEPTH		8	// Entries per UART FIFO, a power of two.

`endif

// File: verilog/ioPeriphPkg.sv
package ioPeriphPkg;

	typedef enum logic [1:0]
	{
		opIdle	= 2'b00,
		opRead	= 2'b01,
		opWrite	= 2'b10
	} mmioOp;

	typedef enum logic [1:0]
	{
		okReady	= 2'b00,	// Idle, or the address is not mapped.
		okOk	= 2'b01
	} mmioOk;

	typedef enum logic [3:0]
	{
		selNone, selTimerLo, selTimerHi, selRxData, selTxData, selStatus,
		selPins, selOut, selDir, selSet, selClear
	} regSel;

endpackage

// File: verilog/mmioDecode.sv
`timescale 1ns/1ps
`include "ioPeriph_consts.svh"

module mmioDecode(
	input logic clock,
	input logic rstN,
	input ioPeriphPkg::mmioOp mmioOp,
	input logic [15:0] mmioAddr,
	output ioPeriphPkg::regSel sel,
	output logic rdStrobe,
	output logic wrStrobe
);
	ioPeriphPkg::mmioOp lastOp;

	always_comb
	begin
		case (mmioAddr)
			`REG_TIMER_LO:	sel = ioPeriphPkg::selTimerLo;
			`REG_TIMER_HI:	sel = ioPeriphPkg::selTimerHi;
			`REG_RX_DATA:	sel = ioPeriphPkg::selRxData;
			`REG_TX_DATA:	sel = ioPeriphPkg::selTxData;
			`REG_STATUS:	sel = ioPeriphPkg::selStatus;
			`REG_PINS:		sel = ioPeriphPkg::selPins;
			`REG_OUT:		sel = ioPeriphPkg::selOut;
			`REG_DIR:		sel = ioPeriphPkg::selDir;
			`REG_SET:		sel = ioPeriphPkg::selSet;
			`REG_CLEAR:		sel = ioPeriphPkg::selClear;
			default:		sel = ioPeriphPkg::selNone;
		endcase
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			lastOp <= ioPeriphPkg::opIdle;
		else
			lastOp <= mmioOp;
	end

	// A request has its side effects only in the cycle where it begins.
	assign rdStrobe = (mmioOp == ioPeriphPkg::opRead) && (lastOp != ioPeriphPkg::opRead);
	assign wrStrobe = (mmioOp == ioPeriphPkg::opWrite) && (lastOp != ioPeriphPkg::opWrite);

	opKnown: assert property (@(posedge clock) disable iff (!rstN) !$isunknown(mmioOp));

endmodule

// File: verilog/gpioBank.sv
`timescale 1ns/1ps

module gpioBank(
	input logic clock,
	input logic rstN,
	input ioPeriphPkg::regSel sel,
	input logic wrStrobe,
	input logic [31:0] mmioWData,
	output logic [31:0] outReg,
	output logic [31:0] dirReg
);

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			outReg <= '0;
			dirReg <= '0;	// All pins start as inputs.
		end
		else if (wrStrobe)
		begin
			case (sel)
				ioPeriphPkg::selOut:
					outReg <= mmioWData;
				ioPeriphPkg::selDir:
					dirReg <= mmioWData;
				ioPeriphPkg::selSet:
					outReg <= outReg | mmioWData;	// Set only the bits written as one.
				ioPeriphPkg::selClear:
					outReg <= outReg & ~mmioWData;
				default:
				begin
				end
			endcase
		end
	end

endmodule

// File: verilog/tickTimer.sv
`timescale 1ns/1ps
`include "ioPeriph_consts.svh"

module tickTimer(
	input logic clock,
	input logic rstN,
	output logic [63:0] ticks
);
	localparam int PreW = $clog2(`TICK_DIV + 1);

	logic [PreW-1:0] preCount;
	logic tickNow;

	assign tickNow = preCount == PreW'(`TICK_DIV - 1);	// Last clock of a microsecond.

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			preCount <= '0;
			ticks <= '0;
		end
		else
		begin
			preCount <= tickNow ? '0 : preCount + 1'b1;
			if (tickNow)
				ticks <= ticks + 64'd1;
		end
	end

endmodule

// File: verilog/uartTx.sv
`timescale 1ns/1ps
`include "ioPeriph_consts.svh"

module uartTx(
	input logic clock,
	input logic rstN,
	input ioPeriphPkg::regSel sel,
	input logic wrStrobe,
	input logic [31:0] mmioWData,
	output logic txFull,
	output logic txEmpty,
	output logic uartTxPin
);
	localparam int PtrW = $clog2(`FIFO_DEPTH);
	localparam int CntW = $clog2(`BIT_CLKS);

	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState;

	logic [7:0] fifoMem [`FIFO_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0] count;
	txState state;
	logic [CntW-1:0] bitTimer;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic push;
	logic pop;
	logic bitDone;

	assign push = wrStrobe && (sel == ioPeriphPkg::selTxData) && !txFull;
	assign pop = (state == txIdle) && (count != '0);	// The shifter takes the head when idle.
	assign bitDone = bitTimer == CntW'(`BIT_CLKS - 1);
	assign txFull = count == (PtrW + 1)'(`FIFO_DEPTH);
	assign txEmpty = (count == '0) && (state == txIdle);	// Nothing queued and nothing in flight.

	always_ff @(posedge clock)
	begin
		if (push)
			fifoMem[wrPtr] <= mmioWData[7:0];
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= txIdle;
			bitTimer <= '0;
			bitIdx <= '0;
			uartTxPin <= 1'b1;
		end
		else
		begin
			bitTimer <= (state == txIdle || bitDone) ? '0 : bitTimer + 1'b1;
			case (state)
				txIdle:
					if (pop)
					begin
						shiftReg <= fifoMem[rdPtr];
						uartTxPin <= 1'b0;	// Start bit.
						state <= txStart;
					end
				txStart:
					if (bitDone)
					begin
						uartTxPin <= shiftReg[0];
						shiftReg <= shiftReg >> 1;
						bitIdx <= '0;
						state <= txData;
					end
				txData:
					if (bitDone)
					begin
						if (bitIdx == 3'd7)
						begin
							uartTxPin <= 1'b1;	// Stop bit.
							state <= txStop;
						end
						else
						begin
							uartTxPin <= shiftReg[0];
							shiftReg <= shiftReg >> 1;
							bitIdx <= bitIdx + 1'b1;
						end
					end
				default:
					if (bitDone)
						state <= txIdle;
			endcase
		end
	end

	noPushWhenFull: assert property (@(posedge clock) disable iff (!rstN)
		txFull |=> $stable(wrPtr));

endmodule

// File: verilog/uartRx.sv
`timescale 1ns/1ps
`include "ioPeriph_consts.svh"

module uartRx(
	input logic clock,
	input logic rstN,
	input ioPeriphPkg::regSel sel,
	input logic rdStrobe,
	input logic uartRxPin,
	output logic [7:0] rxData,
	output logic rxFull,
	output logic rxReady
);
	localparam int PtrW = $clog2(`FIFO_DEPTH);
	localparam int CntW = $clog2(`BIT_CLKS);

	typedef enum logic [1:0] {rxIdle, rxStart, rxBits, rxStop} rxState;

	logic [7:0] fifoMem [`FIFO_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0] count;
	logic [2:0] rxSync;
	logic rxBit;
	rxState state;
	logic [CntW-1:0] bitTimer;
	logic [3:0] bitIdx;
	logic [7:0] shiftReg;
	logic [7:0] holdReg;
	logic [7:0] headByte;
	logic readNow;
	logic push;
	logic pop;
	logic bitDone;

	assign rxBit = rxSync[1];
	assign bitDone = bitTimer == CntW'(`BIT_CLKS - 1);
	assign rxFull = count == (PtrW + 1)'(`FIFO_DEPTH);
	assign rxReady = count != '0;
	assign readNow = rdStrobe && (sel == ioPeriphPkg::selRxData);
	assign pop = readNow && rxReady;
	assign push = (state == rxStop) && bitDone && rxBit && !rxFull;	// Framing errors are dropped.
	assign headByte = rxReady ? fifoMem[rdPtr] : 8'h00;
	assign rxData = readNow ? headByte : holdReg;	// The popping read sees its byte at once.

	always_ff @(posedge clock)
	begin
		if (push)
			fifoMem[wrPtr] <= shiftReg;
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			holdReg <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (readNow)
				holdReg <= headByte;
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			rxSync <= 3'b111;
			state <= rxIdle;
			bitTimer <= '0;
			bitIdx <= '0;
		end
		else
		begin
			rxSync <= {rxSync[1:0], uartRxPin};
			case (state)
				rxIdle:
				begin
					bitTimer <= '0;
					if (rxSync[2] && !rxBit)
						state <= rxStart;
				end
				rxStart:
					// Half a bit in, the start bit must still be low.
					if (bitTimer == CntW'(`BIT_CLKS / 2 - 1))
					begin
						bitTimer <= '0;
						bitIdx <= '0;
						state <= rxBit ? rxIdle : rxBits;
					end
					else
						bitTimer <= bitTimer + 1'b1;
				rxBits:
					if (bitDone)
					begin
						bitTimer <= '0;
						shiftReg <= {rxBit, shiftReg[7:1]};	// LSB arrives first.
						if (bitIdx == 4'd7)
							state <= rxStop;
						else
							bitIdx <= bitIdx + 1'b1;
					end
					else
						bitTimer <= bitTimer + 1'b1;
				default:
					if (bitDone)
						state <= rxIdle;
					else
						bitTimer <= bitTimer + 1'b1;
			endcase
		end
	end

	bitIdxRange: assert property (@(posedge clock) disable iff (!rstN) bitIdx <= 4'd7);

endmodule

// File: verilog/mmioResult.sv
`timescale 1ns/1ps

module mmioResult(
	input logic clock,
	input logic rstN,
	input ioPeriphPkg::regSel sel,
	input ioPeriphPkg::mmioOp mmioOp,
	input logic [63:0] ticks,
	input logic [31:0] outReg,
	input logic [31:0] dirReg,
	input logic [31:0] gpioIn,
	input logic [7:0] rxData,
	input logic txFull,
	input logic txEmpty,
	input logic rxFull,
	input logic rxReady,
	output logic [31:0] mmioRData,
	output ioPeriphPkg::mmioOk mmioOk
);
	logic [31:0] readMux;

	always_comb
	begin
		case (sel)
			ioPeriphPkg::selTimerLo:	readMux = ticks[31:0];
			ioPeriphPkg::selTimerHi:	readMux = ticks[63:32];
			ioPeriphPkg::selRxData:		readMux = {24'h0, rxData};
			ioPeriphPkg::selStatus:		readMux = {28'h0, txFull, txEmpty, rxFull, rxReady};
			ioPeriphPkg::selPins:		readMux = gpioIn;
			ioPeriphPkg::selOut,
			ioPeriphPkg::selSet,
			ioPeriphPkg::selClear:		readMux = outReg;
			ioPeriphPkg::selDir:		readMux = dirReg;
			default:					readMux = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			mmioOk <= ioPeriphPkg::okReady;
			mmioRData <= '0;
		end
		else if (mmioOp == ioPeriphPkg::opIdle)
		begin
			mmioOk <= ioPeriphPkg::okReady;
			mmioRData <= '0;
		end
		else if (mmioOk != ioPeriphPkg::okOk)
		begin
			// Once answered, the reply holds until the master goes idle.
			mmioOk <= (sel == ioPeriphPkg::selNone) ? ioPeriphPkg::okReady : ioPeriphPkg::okOk;
			mmioRData <= readMux;
		end
	end

	readyAfterIdle: assert property (@(posedge clock) disable iff (!rstN)
		mmioOp == ioPeriphPkg::opIdle |=> mmioOk == ioPeriphPkg::okReady);

endmodule

// File: verilog/ioPeriph.sv
`timescale 1ns/1ps

module ioPeriph(
	input logic clock,
	input logic rstN,
	input ioPeriphPkg::mmioOp mmioOp,
	input logic [15:0] mmioAddr,
	input logic [31:0] mmioWData,
	input logic [31:0] gpioIn,
	input logic uartRxPin,
	output logic [31:0] mmioRData,
	output ioPeriphPkg::mmioOk mmioOk,
	output logic [31:0] gpioOut,
	output logic [31:0] gpioOe,
	output logic uartTxPin
);
	ioPeriphPkg::regSel sel;
	logic rdStrobe;
	logic wrStrobe;
	logic [63:0] ticks;
	logic txFull;
	logic txEmpty;
	logic [7:0] rxData;
	logic rxFull;
	logic rxReady;

	mmioDecode uDecode(.clock, .rstN, .mmioOp, .mmioAddr, .sel, .rdStrobe, .wrStrobe);

	// The GPIO registers drive the pins directly.
	gpioBank uGpio(.clock, .rstN, .sel, .wrStrobe, .mmioWData,
		.outReg(gpioOut), .dirReg(gpioOe));

	tickTimer uTimer(.clock, .rstN, .ticks);

	uartTx uTx(.clock, .rstN, .sel, .wrStrobe, .mmioWData, .txFull, .txEmpty, .uartTxPin);

	uartRx uRx(.clock, .rstN, .sel, .rdStrobe, .uartRxPin, .rxData, .rxFull, .rxReady);

	mmioResult uResult(.clock, .rstN, .sel, .mmioOp, .ticks,
		.outReg(gpioOut), .dirReg(gpioOe), .gpioIn, .rxData,
		.txFull, .txEmpty, .rxFull, .rxReady, .mmioRData, .mmioOk);

endmodule

// File: verification/ioPeriphChecker.sv
`timescale 1ns/1ps
`include "ioPeriph_consts.svh"

module ioPeriphChecker(
	input logic clock,
	input logic rstN,
	input ioPeriphPkg::mmioOp mmioOp,
	input logic [15:0] mmioAddr,
	input logic [31:0] mmioWData,
	input logic [31:0] gpioIn,
	input logic uartRxPin,
	input logic [31:0] mmioRData,
	input ioPeriphPkg::mmioOk mmioOk,
	input logic [31:0] gpioOut,
	input logic [31:0] gpioOe,
	input logic uartTxPin,
	output int errorCount,
	output int checkCount
);
	localparam int FrameClks = 10 * `BIT_CLKS;

	logic [31:0] modelOut;
	logic [31:0] modelDir;
	logic [7:0] txByte [$];
	int txStart [$];
	logic [7:0] rxQueue [$];
	int shifterFree;
	int cycle;
	ioPeriphPkg::mmioOp prevOp;
	ioPeriphPkg::mmioOp respOp;
	ioPeriphPkg::mmioOk expOk;
	logic respDue;
	logic checkData;
	logic [31:0] expData;
	logic [15:0] respAddr;
	string respName;
	int reqCycle;
	int loCycle;
	logic haveLo;
	logic [31:0] lastLo;
	logic [31:0] lastHi;

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("[ERROR] %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	function automatic logic isMapped(input logic [15:0] addr);
		case (addr)
			`REG_TIMER_LO, `REG_TIMER_HI, `REG_RX_DATA, `REG_TX_DATA, `REG_STATUS,
			`REG_PINS, `REG_OUT, `REG_DIR, `REG_SET, `REG_CLEAR:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// A frame is on the receive side once its ten bit times have passed.
	task automatic deliverBytes();
		logic [7:0] b;
		while (txStart.size() != 0 && txStart[0] + FrameClks <= cycle)
		begin
			b = txByte.pop_front();
			void'(txStart.pop_front());
			if (rxQueue.size() < `FIFO_DEPTH)
				rxQueue.push_back(b);
		end
	endtask

	task automatic pushTx(input logic [7:0] b);
		int waiting;
		int start;
		waiting = 0;
		foreach (txStart[i])
			if (txStart[i] >= cycle)
				waiting++;	// Queued but not yet on the line.
		if (waiting < `FIFO_DEPTH)
		begin
			start = (cycle + 1 > shifterFree) ? cycle + 1 : shifterFree;
			txStart.push_back(start);
			txByte.push_back(b);
			shifterFree = start + FrameClks + 1;
		end
	endtask

	task automatic startRequest();
		respDue = 1'b1;
		respOp = mmioOp;
		respAddr = mmioAddr;
		reqCycle = cycle;
		checkData = 1'b0;
		expData = '0;
		respName = "unmapped";
		expOk = isMapped(mmioAddr) ? ioPeriphPkg::okOk : ioPeriphPkg::okReady;
		deliverBytes();
		if (mmioOp == ioPeriphPkg::opRead)
		begin
			checkData = 1'b1;
			case (mmioAddr)
				`REG_OUT, `REG_SET, `REG_CLEAR:
				begin
					respName = "out read";
					expData = modelOut;
				end
				`REG_DIR:
				begin
					respName = "dir read";
					expData = modelDir;
				end
				`REG_PINS:
				begin
					respName = "pins read";
					expData = gpioIn;
				end
				`REG_RX_DATA:
				begin
					respName = "rx data read";
					if (rxQueue.size() != 0)
						expData = {24'h0, rxQueue.pop_front()};
				end
				`REG_STATUS:
				begin
					respName = "status read";
					// Only a quiet line gives a status that the model can predict exactly.
					checkData = txStart.size() == 0 && cycle >= shifterFree + `BIT_CLKS / 2;
					expData = {28'h0, 1'b0, 1'b1, rxQueue.size() == `FIFO_DEPTH,
						rxQueue.size() != 0};
				end
				`REG_TIMER_LO, `REG_TIMER_HI:
				begin
					respName = "timer read";
					checkData = 1'b0;
				end
				`REG_TX_DATA:
					respName = "tx data read";
				default:
				begin
				end
			endcase
		end
		else
		begin
			if (isMapped(mmioAddr))
				respName = "write";
			case (mmioAddr)
				`REG_OUT:	modelOut = mmioWData;
				`REG_DIR:	modelDir = mmioWData;
				`REG_SET:	modelOut = modelOut | mmioWData;
				`REG_CLEAR:	modelOut = modelOut & ~mmioWData;
				`REG_TX_DATA:	pushTx(mmioWData[7:0]);
				default:
				begin
				end
			endcase
		end
	endtask

	task automatic checkResponse();
		logic [31:0] delta;
		int span;
		respDue = 1'b0;
		compare({respName, " status"}, 32'(expOk), 32'(mmioOk));
		if (checkData)
			compare(respName, expData, mmioRData);
		if (respOp == ioPeriphPkg::opRead && respAddr == `REG_TIMER_LO)
		begin
			if (haveLo)
			begin
				span = reqCycle - loCycle;
				delta = mmioRData - lastLo;
				checkCount++;
				if (int'(delta) < span / `TICK_DIV - 1 || int'(delta) > span / `TICK_DIV + 1)
				begin
					errorCount++;
					$display("[ERROR] timer delta: expected %0d to %0d actual %0d",
						span / `TICK_DIV - 1, span / `TICK_DIV + 1, int'(delta));
				end
			end
			haveLo = 1'b1;
			lastLo = mmioRData;
			loCycle = reqCycle;
		end
		if (respOp == ioPeriphPkg::opRead && respAddr == `REG_TIMER_HI)
		begin
			checkCount++;
			if (mmioRData < lastHi)
			begin
				errorCount++;
				$display("[ERROR] timer high: expected at least %h actual %h", lastHi, mmioRData);
			end
			lastHi = mmioRData;
		end
	endtask

	// Inputs change just after the rising edge, so the falling edge sees everything settled.
	always @(negedge clock)
	begin
		if (!rstN)
		begin
			compare("reset status", 32'(ioPeriphPkg::okReady), 32'(mmioOk));
			compare("reset gpioOe", 32'h0, gpioOe);
			compare("reset tx pin", 32'h1, 32'(uartTxPin));
			modelOut = '0;
			modelDir = '0;
			txByte.delete();
			txStart.delete();
			rxQueue.delete();
			shifterFree = 0;
			cycle = 0;
			prevOp = ioPeriphPkg::opIdle;
			respDue = 1'b0;
			haveLo = 1'b0;
			lastHi = '0;
		end
		else
		begin
			cycle++;
			if (respDue)
				checkResponse();
			else if (prevOp == ioPeriphPkg::opIdle)
				compare("idle status", 32'(ioPeriphPkg::okReady), 32'(mmioOk));
			compare("gpioOut", modelOut, gpioOut);
			compare("gpioOe", modelDir, gpioOe);
			if (mmioOp != ioPeriphPkg::opIdle && prevOp == ioPeriphPkg::opIdle)
				startRequest();
			prevOp = mmioOp;
		end
	end

endmodule

// File: verification/ioPeriphTb.sv
`timescale 1ns/1ps
`include "ioPeriph_consts.svh"

module ioPeriphTb;
	localparam int NumGpio = 60;
	localparam int NumTimer = 12;
	localparam int NumBursts = 6;
	localparam int MaxBytes = NumBursts * 8 + 12;
	// A timer gap of up to 32 clocks counts as eight requests.
	localparam int NumRequests = NumGpio * 5 + NumTimer * (3 + 8) + MaxBytes * 3
		+ (NumBursts + 1) * 2;
	localparam int CycleLimit = NumRequests * 4 + MaxBytes * 10 * `BIT_CLKS * 2 + 200;

	logic clock;
	logic rstN;
	ioPeriphPkg::mmioOp mmioOp;
	logic [15:0] mmioAddr;
	logic [31:0] mmioWData;
	logic [31:0] gpioIn;
	logic uartRxPin;
	logic [31:0] mmioRData;
	ioPeriphPkg::mmioOk mmioOk;
	logic [31:0] gpioOut;
	logic [31:0] gpioOe;
	logic uartTxPin;
	int seed;
	int errorCount;
	int checkCount;
	int cycleCount;
	logic [31:0] rnd;
	logic [31:0] rdata;

	assign uartRxPin = uartTxPin;	// Serial loopback.

	ioPeriph u_dut(.clock, .rstN, .mmioOp, .mmioAddr, .mmioWData, .gpioIn, .uartRxPin,
		.mmioRData, .mmioOk, .gpioOut, .gpioOe, .uartTxPin);

	ioPeriphChecker uChecker(.clock, .rstN, .mmioOp, .mmioAddr, .mmioWData, .gpioIn,
		.uartRxPin, .mmioRData, .mmioOk, .gpioOut, .gpioOe, .uartTxPin,
		.errorCount, .checkCount);

	always #5 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// Holds the request until it is answered, or for two cycles if it never is.
	task automatic request(input ioPeriphPkg::mmioOp op, input logic [15:0] addr,
		input logic [31:0] data, output logic [31:0] result);
		logic [31:0] noise;
		int waited;
		@(posedge clock);
		#1;
		noise = $random(seed);
		gpioIn = (gpioOut & gpioOe) | (noise & ~gpioOe);
		mmioOp = op;
		mmioAddr = addr;
		mmioWData = data;
		@(posedge clock);
		#1;
		waited = 1;
		while (mmioOk != ioPeriphPkg::okOk && waited < 2)
		begin
			@(posedge clock);
			#1;
			waited++;
		end
		result = mmioRData;
		mmioOp = ioPeriphPkg::opIdle;
	endtask

	task automatic readReg(input logic [15:0] addr, output logic [31:0] result);
		request(ioPeriphPkg::opRead, addr, 32'h0, result);
	endtask

	task automatic writeReg(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		request(ioPeriphPkg::opWrite, addr, data, unused);
	endtask

	task automatic sendBurst(input int len);
		logic [31:0] data;
		for (int j = 0; j < len; j++)
		begin
			data = $random(seed);
			writeReg(`REG_TX_DATA, data);
		end
	endtask

	// Waits until the transmitter is idle and received data stays available.
	task automatic waitQuiet();
		logic [31:0] status;
		int stable;
		stable = 0;
		while (stable < 2)
		begin
			readReg(`REG_STATUS, status);
			if (status[2] && status[0])
				stable++;
			else
				stable = 0;
		end
	endtask

	task automatic drainRx();
		logic [31:0] status;
		logic [31:0] data;
		readReg(`REG_STATUS, status);
		while (status[0])
		begin
			readReg(`REG_RX_DATA, data);
			readReg(`REG_STATUS, status);
		end
		readReg(`REG_RX_DATA, data);	// The FIFO is empty now.
	endtask

	initial
	begin
		seed = 32'h7640_87d5;
		clock = 1'b0;
		rstN = 1'b0;
		mmioOp = ioPeriphPkg::opIdle;
		mmioAddr = '0;
		mmioWData = '0;
		gpioIn = '0;
		cycleCount = 0;
		repeat (2) @(posedge clock);
		#1;
		rstN = 1'b1;

		for (int i = 0; i < NumGpio; i++)
		begin
			rnd = $random(seed);
			case (rnd[1:0])
				2'd0:	writeReg(`REG_OUT, $random(seed));
				2'd1:	writeReg(`REG_DIR, $random(seed));
				2'd2:	writeReg(`REG_SET, $random(seed));
				2'd3:	writeReg(`REG_CLEAR, $random(seed));
			endcase
			readReg(`REG_OUT, rdata);
			readReg(`REG_DIR, rdata);
			readReg(`REG_PINS, rdata);
			rnd = $random(seed);
			// Nothing is mapped below 16'hE000.
			request(rnd[16] ? ioPeriphPkg::opRead : ioPeriphPkg::opWrite,
				{4'h1, rnd[11:0]}, rnd, rdata);
		end

		for (int i = 0; i < NumTimer; i++)
		begin
			readReg(`REG_TIMER_LO, rdata);
			rnd = $random(seed);
			repeat (rnd[4:0]) @(posedge clock);
			readReg(`REG_TIMER_LO, rdata);
			readReg(`REG_TIMER_HI, rdata);
		end

		for (int i = 0; i < NumBursts; i++)
		begin
			rnd = $random(seed);
			sendBurst(int'(rnd[2:0]) + 1);
			waitQuiet();
			drainRx();
		end
		sendBurst(12);
		waitQuiet();
		drainRx();

		repeat (4) @(posedge clock);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: ioPeriph.f
+incdir+include
verilog/ioPeriphPkg.sv
verilog/mmioDecode.sv
verilog/gpioBank.sv
verilog/tickTimer.sv
verilog/uartTx.sv
verilog/uartRx.sv
verilog/mmioResult.sv
verilog/ioPeriph.sv
verification/ioPeriphChecker.sv
verification/ioPeriphTb.sv

// File: build.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f ioPeriph.f --top-module ioPeriphTb -o ioPeriphSim
./obj_dir/ioPeriphSim > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
echo "Simulation finished without a reported failure"
